// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --assert --timing -Wno-fatal --top-module alu_tb -f vlog.f -o alu_sim &&
./obj_dir/alu_sim +verilator+error+limit+1000 | tee /dev/stderr | grep -qx "NO ERRORS" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

// File: src/alu_execute.sv
// Execute stage running the prefix adder, registering result flags and the stored carry
`timescale 1ns/10ps

module alu_execute (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              dec_valid,
	input  alu_pkg::dec_cmd_t dec,
	output logic              exe_valid,
	output alu_pkg::alu_res_t exe_res
);

	logic           carry_q;
	logic           cin;
	alu_pkg::word_t sum;
	logic           cout;
	logic           zero;
	logic           overflow;

	// Constant carry-in equals the subtract flag
	assign cin = dec.use_carry ? carry_q : dec.sub;

	ling_prefix_adder u_adder (
		.a    (dec.a),
		.b    (dec.b),
		.cin  (cin),
		.sum  (sum),
		.cout (cout)
	);

	assign zero = (sum == '0);

	// Same-sign inputs with a sum of the other sign
	assign overflow = (dec.a[alu_pkg::WORD_W-1] == dec.b[alu_pkg::WORD_W-1]) &&
		(sum[alu_pkg::WORD_W-1] != dec.a[alu_pkg::WORD_W-1]);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			exe_valid <= 1'b0;
			carry_q <= 1'b0;
		end else begin
			exe_valid <= dec_valid;
			if (dec_valid) begin
				carry_q <= cout;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (dec_valid) begin
			exe_res.tag <= dec.tag;
			exe_res.sum <= sum;
			exe_res.carry <= cout;
			exe_res.zero <= zero;
			exe_res.overflow <= overflow;
		end
	end

endmodule

// File: src/alu_pkg.sv
// ALU package with operand widths, operation codes, pipeline structs and credit limits

package alu_pkg;

	// Datapath and tag widths
	localparam int WORD_W = 16;
	localparam int TAG_W = 4;

	// Result FIFO depth and the command credits granted upstream after reset
	localparam int RES_DEPTH = 4;
	// Result credits held toward the downstream agent after reset
	localparam int OUT_CREDITS = 2;

	localparam int QPTR_W = $clog2(RES_DEPTH);
	localparam int CRED_W = $clog2(OUT_CREDITS + 1);

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [TAG_W-1:0] tag_t;

	// FIFO pointer, FIFO fill level and downstream credit counter
	typedef logic [QPTR_W-1:0] qptr_t;
	typedef logic [QPTR_W:0] qcnt_t;
	typedef logic [CRED_W-1:0] credit_t;

	typedef enum logic [1:0] {
		OP_ADD  = 2'd0,
		OP_SUB  = 2'd1,
		OP_ADDC = 2'd2,
		OP_SUBB = 2'd3
	} alu_op_e;

	// Command as sent by the upstream agent
	typedef struct packed {
		alu_op_e op;
		tag_t    tag;
		word_t   a;
		word_t   b;
	} alu_cmd_t;

	// Decoded command with b already inverted for subtraction
	typedef struct packed {
		tag_t  tag;
		word_t a;
		word_t b;
		logic  use_carry;
		logic  sub;
	} dec_cmd_t;

	typedef struct packed {
		tag_t  tag;
		word_t sum;
		logic  carry;
		logic  zero;
		logic  overflow;
	} alu_res_t;

endpackage

// File: src/alu_top.sv
// Top level of the credit-controlled adder/subtractor with decode, execute and result stages
`timescale 1ns/10ps

module alu_top (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              cmd_valid,
	input  alu_pkg::alu_cmd_t cmd,
	output logic              cmd_credit,
	output logic              res_valid,
	output alu_pkg::alu_res_t res,
	input  logic              res_credit
);

	logic              dec_valid;
	alu_pkg::dec_cmd_t dec;
	logic              exe_valid;
	alu_pkg::alu_res_t exe_res;

	op_decode u_decode (
		.clk       (clk),
		.arst_n    (arst_n),
		.cmd_valid (cmd_valid),
		.cmd       (cmd),
		.dec_valid (dec_valid),
		.dec       (dec)
	);

	alu_execute u_execute (
		.clk       (clk),
		.arst_n    (arst_n),
		.dec_valid (dec_valid),
		.dec       (dec),
		.exe_valid (exe_valid),
		.exe_res   (exe_res)
	);

	result_queue u_result (
		.clk        (clk),
		.arst_n     (arst_n),
		.exe_valid  (exe_valid),
		.exe_res    (exe_res),
		.res_credit (res_credit),
		.res_valid  (res_valid),
		.res        (res),
		.cmd_credit (cmd_credit)
	);

endmodule

// File: src/ling_prefix_adder.sv
// 16-bit Knowles parallel-prefix adder in Ling form with pseudo-carries H and I
`timescale 1ns/10ps

module ling_prefix_adder (
	input  alu_pkg::word_t a,
	input  alu_pkg::word_t b,
	input  logic           cin,
	output alu_pkg::word_t sum,
	output logic           cout
);

	// Reduced black cell forms H from two generates and I from two propagates
	function automatic logic [1:0] rblk_cell(input logic g_hi, input logic g_lo,
			input logic p_hi, input logic p_lo);
		return {g_hi | g_lo, p_hi & p_lo};
	endfunction

	function automatic logic rgry_cell(input logic g_hi, input logic g_lo);
		return g_hi | g_lo;
	endfunction

	function automatic logic [1:0] black_cell(input logic h_hi, input logic i_hi,
			input logic h_lo, input logic i_lo);
		return {h_hi | (i_hi & h_lo), i_hi & i_lo};
	endfunction

	function automatic logic grey_cell(input logic h_hi, input logic i_hi, input logic h_lo);
		return h_hi | (i_hi & h_lo);
	endfunction

	// Bit 0 holds the carry-in and operand bit k sits at position k+1
	logic [16:0] p;
	logic [16:0] g;
	logic [15:0] h1;
	logic [15:0] h2;
	logic [15:0] h3;
	logic [15:0] h4;
	logic [15:2] i1;
	logic [15:4] i2;
	logic [15:8] i3;
	logic [16:1] h;
	logic [16:1] c;

	assign p = {a | b, 1'b1};
	assign g = {a & b, cin};

	// Span 1 uses reduced cells straight from g and p
	assign h1[0] = g[0];
	assign h1[1] = rgry_cell(g[1], g[0]);
	for (genvar j = 2; j < 16; j++) begin : g_span1
		assign {h1[j], i1[j]} = rblk_cell(g[j], g[j-1], p[j-1], p[j-2]);
	end

	// Span 2
	for (genvar j = 0; j < 16; j++) begin : g_span2
		if (j < 2) begin : g_pass
			assign h2[j] = h1[j];
		end else if (j < 4) begin : g_grey
			assign h2[j] = grey_cell(h1[j], i1[j], h1[j-2]);
		end else begin : g_black
			assign {h2[j], i2[j]} = black_cell(h1[j], i1[j], h1[j-2], i1[j-2]);
		end
	end

	// Span 4
	for (genvar j = 0; j < 16; j++) begin : g_span4
		if (j < 4) begin : g_pass
			assign h3[j] = h2[j];
		end else if (j < 8) begin : g_grey
			assign h3[j] = grey_cell(h2[j], i2[j], h2[j-4]);
		end else begin : g_black
			assign {h3[j], i3[j]} = black_cell(h2[j], i2[j], h2[j-4], i2[j-4]);
		end
	end

	// Span 8 reuses the odd low-side prefixes with a Knowles fanout of two
	for (genvar j = 0; j < 16; j++) begin : g_span8
		if (j < 8) begin : g_pass
			assign h4[j] = h3[j];
		end else begin : g_grey
			assign h4[j] = grey_cell(h3[j], i3[j], h3[(j-8) | 1]);
		end
	end

	// Real carries are c[k+1] = p[k] & H[k:0]
	assign c = {p[15:1] & h4[15:1], h4[0]};
	assign h = {g[16] | c[16], h4[15:1]};

	assign sum = (p[16:1] ^ h) | (g[16:1] & c);
	assign cout = p[16] & h[16];

endmodule

// File: src/op_decode.sv
// Decode stage that registers a command and turns its operation into adder controls
`timescale 1ns/10ps

module op_decode (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               cmd_valid,
	input  alu_pkg::alu_cmd_t  cmd,
	output logic               dec_valid,
	output alu_pkg::dec_cmd_t  dec
);

	logic sub_op;
	logic use_carry;

	// Operation to inversion and carry-in source
	always_comb begin
		sub_op = 1'b0;
		use_carry = 1'b0;
		case (cmd.op)
			alu_pkg::OP_ADD: begin
				sub_op = 1'b0;
				use_carry = 1'b0;
			end
			alu_pkg::OP_SUB: begin
				sub_op = 1'b1;
				use_carry = 1'b0;
			end
			alu_pkg::OP_ADDC: begin
				sub_op = 1'b0;
				use_carry = 1'b1;
			end
			alu_pkg::OP_SUBB: begin
				sub_op = 1'b1;
				use_carry = 1'b1;
			end
			default: begin
				sub_op = 1'b0;
				use_carry = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			dec_valid <= 1'b0;
		end else begin
			dec_valid <= cmd_valid;
		end
	end

	// Payload only loads on an accepted command
	always_ff @(posedge clk) begin
		if (cmd_valid) begin
			dec.tag <= cmd.tag;
			dec.a <= cmd.a;
			dec.b <= sub_op ? ~cmd.b : cmd.b;
			dec.use_carry <= use_carry;
			dec.sub <= sub_op;
		end
	end

endmodule

// File: src/result_queue.sv
// Result FIFO that issues against downstream credits and returns command credits
`timescale 1ns/10ps

module result_queue (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              exe_valid,
	input  alu_pkg::alu_res_t exe_res,
	input  logic              res_credit,
	output logic              res_valid,
	output alu_pkg::alu_res_t res,
	output logic              cmd_credit
);

	alu_pkg::alu_res_t mem [alu_pkg::RES_DEPTH];
	alu_pkg::qptr_t    wr_ptr;
	alu_pkg::qptr_t    rd_ptr;
	alu_pkg::qcnt_t    count;
	alu_pkg::credit_t  credits;
	logic              issue;

	// Head leaves when something is queued and a credit is held
	assign issue = (count != '0) && (credits != '0);

	assign res_valid = issue;
	assign cmd_credit = issue;
	assign res = mem[rd_ptr];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credits <= alu_pkg::credit_t'(alu_pkg::OUT_CREDITS);
		end else begin
			if (exe_valid) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (issue) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({exe_valid, issue})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			// Returned credit and an issue in one cycle cancel out
			case ({res_credit, issue})
				2'b10: credits <= credits + 1'b1;
				2'b01: credits <= credits - 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	// Command credits bound the fill level, so a write always finds room
	always_ff @(posedge clk) begin
		if (exe_valid) begin
			mem[wr_ptr] <= exe_res;
		end
	end

endmodule

// File: verification/alu_asserts.sv
// Bound checker for reset quiet state, credit use and result integrity of the adder/subtractor
`timescale 1ns/10ps

module alu_asserts (
	input logic              clk,
	input logic              arst_n,
	input logic              cmd_credit,
	input logic              res_valid,
	input logic              res_credit,
	input alu_pkg::alu_res_t res
);

	int held;
	int fail_reset = 0;
	int fail_credit = 0;
	int fail_pair = 0;
	int fail_x = 0;
	int failures;

	// Downstream credits the DUT holds
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			held <= alu_pkg::OUT_CREDITS;
		end else begin
			held <= held + int'(res_credit) - int'(res_valid);
		end
	end

	assign failures = fail_reset + fail_credit + fail_pair + fail_x;

	a_reset_quiet: assert property (@(posedge clk) (!arst_n || $rose(arst_n)) |->
		(!res_valid && !cmd_credit))
		else begin $error("Output active in or right after reset"); fail_reset++; end
	a_credit_held: assert property (@(posedge clk) disable iff (!arst_n) res_valid |-> held > 0)
		else begin $error("Result issued without a credit"); fail_credit++; end
	a_credit_pair: assert property (@(posedge clk) cmd_credit == res_valid)
		else begin $error("Command credit and result issue differ"); fail_pair++; end
	a_res_known: assert property (@(posedge clk) disable iff (!arst_n) res_valid |-> !$isunknown(res))
		else begin $error("Unknown bits on an issued result"); fail_x++; end

endmodule

bind alu_top alu_asserts u_asserts (
	.clk        (clk),
	.arst_n     (arst_n),
	.cmd_credit (cmd_credit),
	.res_valid  (res_valid),
	.res_credit (res_credit),
	.res        (res)
);

// File: verification/alu_tb.sv
// Testbench for the credit-controlled adder/subtractor with reference model and scoreboard
`timescale 1ns/10ps

module alu_tb;

	localparam int BP_CMDS = alu_pkg::RES_DEPTH + alu_pkg::OUT_CREDITS;
	localparam int TOTAL_CMDS = 7 + 8 + 300 + 3 * BP_CMDS + 4;
	localparam int CYCLE_LIMIT = TOTAL_CMDS * 20 + 200;

	logic              clk;
	logic              arst_n;
	logic              cmd_valid;
	alu_pkg::alu_cmd_t cmd;
	logic              cmd_credit;
	logic              res_valid;
	alu_pkg::alu_res_t res;
	logic              res_credit;

	int seed = 32142;
	int cycles = 0;
	int score_errors = 0;
	int proto_errors = 0;
	int assert_errors;
	int cmd_credits = alu_pkg::RES_DEPTH;
	int dut_credits = alu_pkg::OUT_CREDITS;
	int issued = 0;
	int credit_pulses = 0;
	bit hold_credits = 1'b0;
	logic model_carry = 1'b0;
	alu_pkg::tag_t next_tag = '0;
	string test_name = "reset";
	alu_pkg::alu_res_t exp_q[$];

	alu_top DUT (.*);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycles > CYCLE_LIMIT) begin
			$display("Timeout in %s after %0d cycles", test_name, cycles);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	// Arithmetic rule applied in command order
	task automatic predict(alu_pkg::alu_cmd_t c);
		alu_pkg::alu_res_t r;
		alu_pkg::word_t bop;
		logic cin;
		logic [16:0] full;
		bop = (c.op == alu_pkg::OP_SUB || c.op == alu_pkg::OP_SUBB) ? ~c.b : c.b;
		cin = (c.op == alu_pkg::OP_ADDC || c.op == alu_pkg::OP_SUBB) ? model_carry :
			(c.op == alu_pkg::OP_SUB);
		full = {1'b0, c.a} + {1'b0, bop} + {16'd0, cin};
		model_carry = full[16];
		r.tag = c.tag;
		r.sum = full[15:0];
		r.carry = full[16];
		r.zero = (full[15:0] == 16'd0);
		r.overflow = (c.a[15] == bop[15]) && (full[15] != c.a[15]);
		exp_q.push_back(r);
	endtask

	// One cycle with sampling and driving on the falling edge
	task automatic tick();
		alu_pkg::alu_res_t exp;
		@(negedge clk);
		cmd_valid = 1'b0;
		res_credit = 1'b0;
		if (cmd_credit) begin
			cmd_credits++;
			credit_pulses++;
		end
		if (res_valid) begin
			issued++;
			if (dut_credits == 0) begin
				$display("Result tag %h issued while the DUT held no credit", res.tag);
				proto_errors++;
			end else begin
				dut_credits--;
			end
			if (exp_q.size() == 0) begin
				$display("Result tag %h arrived with no command outstanding", res.tag);
				proto_errors++;
			end else begin
				exp = exp_q.pop_front();
				assert (res === exp) else begin
					$display("FAIL %s: expected %p, actual %p", test_name, exp, res);
					score_errors++;
				end
			end
		end
		if (!hold_credits && dut_credits < alu_pkg::OUT_CREDITS && ($random(seed) % 3) != 0) begin
			res_credit = 1'b1;
			dut_credits++;
		end
	endtask

	task automatic send(alu_pkg::alu_op_e op, alu_pkg::word_t a, alu_pkg::word_t b);
		while (cmd_credits == 0) begin
			tick();
		end
		cmd.op = op;
		cmd.tag = next_tag;
		cmd.a = a;
		cmd.b = b;
		cmd_valid = 1'b1;
		cmd_credits--;
		next_tag++;
		predict(cmd);
		tick();
	endtask

	task automatic drain();
		while (exp_q.size() != 0 || dut_credits != alu_pkg::OUT_CREDITS) begin
			tick();
		end
	endtask

	// Items in flight are dropped, so the model starts over
	task automatic apply_reset();
		arst_n = 1'b0;
		hold_credits = 1'b1;
		repeat (3) tick();
		exp_q.delete();
		cmd_credits = alu_pkg::RES_DEPTH;
		dut_credits = alu_pkg::OUT_CREDITS;
		model_carry = 1'b0;
		arst_n = 1'b1;
		hold_credits = 1'b0;
	endtask

	initial begin
		clk = 1'b0;
		arst_n = 1'b0;
		cmd_valid = 1'b0;
		cmd = '0;
		res_credit = 1'b0;
		repeat (3) tick();
		arst_n = 1'b1;
		test_name = "directed";
		send(alu_pkg::OP_ADD, 16'hFFFF, 16'h0001);
		send(alu_pkg::OP_ADD, 16'h7FFF, 16'h0001);
		send(alu_pkg::OP_SUB, 16'h8000, 16'h0001);
		send(alu_pkg::OP_SUB, 16'h1234, 16'h1234);
		send(alu_pkg::OP_ADD, 16'h0000, 16'h0000);
		send(alu_pkg::OP_SUB, 16'h0000, 16'h0001);
		send(alu_pkg::OP_ADD, 16'h8000, 16'h8000);
		drain();
		test_name = "carry_chain";
		send(alu_pkg::OP_ADD, 16'hFFFF, 16'h0001);
		send(alu_pkg::OP_ADDC, 16'h0001, 16'h0000);
		send(alu_pkg::OP_ADD, 16'hFFFF, 16'hFFFF);
		send(alu_pkg::OP_ADDC, 16'hFFFF, 16'h0000);
		send(alu_pkg::OP_ADDC, 16'h1234, 16'h0000);
		send(alu_pkg::OP_SUB, 16'h0000, 16'h0001);
		send(alu_pkg::OP_SUBB, 16'h0000, 16'h0000);
		send(alu_pkg::OP_SUBB, 16'h0001, 16'h0000);
		drain();
		test_name = "random";
		repeat (300) send(alu_pkg::alu_op_e'($random(seed) & 3), 16'($random(seed)),
			16'($random(seed)));
		drain();
		test_name = "back_pressure";
		repeat (3) begin
			hold_credits = 1'b1;
			repeat (BP_CMDS) send(alu_pkg::alu_op_e'($random(seed) & 3), 16'($random(seed)),
				16'($random(seed)));
			repeat (40) tick();
			hold_credits = 1'b0;
			drain();
		end
		test_name = "reset_mid_run";
		// The carry-setting add is the last one executed before reset
		send(alu_pkg::OP_ADD, 16'h0001, 16'h0002);
		send(alu_pkg::OP_ADD, 16'hFFFF, 16'h0001);
		send(alu_pkg::OP_SUB, 16'h0005, 16'h0003);
		apply_reset();
		send(alu_pkg::OP_ADDC, 16'h0005, 16'h0007);
		drain();
		repeat (5) tick();
		if (credit_pulses != issued || cmd_credits != alu_pkg::RES_DEPTH) begin
			$display("Command credits returned (%0d) do not match issued results (%0d)",
				credit_pulses, issued);
			proto_errors++;
		end
		assert_errors = DUT.u_asserts.failures;
		$display("Error counts: scoreboard %0d, protocol %0d, assertions %0d",
			score_errors, proto_errors, assert_errors);
		if (score_errors + proto_errors + assert_errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// File: vlog.f
src/alu_pkg.sv
src/op_decode.sv
src/ling_prefix_adder.sv
src/alu_execute.sv
src/result_queue.sv
src/alu_top.sv
verification/alu_asserts.sv
verification/alu_tb.sv
